// ==== design/clkreqaggr_cfg.svh ====
/* Clock request aggregator defaults */

`ifndef CLKREQAGGR_CFG_SVH
`define CLKREQAGGR_CFG_SVH

// Default number of downstream agents
// Top level and testbench both start from this
`define CLKREQAGGR_CNT 4

// Depth of every synchronizer chain
// Two flops give a single settling cycle for metastability
// Request to acknowledge latency grows by one per extra stage
`define CLKREQAGGR_SYNC_STAGES 2

`endif

// ==== design/clkreqaggr_pkg.sv ====
/* Clock request aggregator types */

package clkreqaggr_pkg;

  // Upstream handshake states
  // UP_IDLE  no upstream request, acknowledge seen low
  // UP_REQ   oclkmreq high, waiting for iclkmack
  // UP_ON    clock granted to every port
  // UP_REL   oclkmreq dropped, waiting for iclkmack low
  typedef enum logic [1:0] {
    UP_IDLE,
    UP_REQ,
    UP_ON,
    UP_REL
  } up_state_t;

  // Per agent handshake states
  // PORT_IDLE  nothing requested
  // PORT_WAIT  request seen, upstream not yet on
  // PORT_ACK   oclkack high to the agent
  // PORT_DROP  request gone, ack low, need still held
  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT,
    PORT_ACK,
    PORT_DROP
  } port_state_t;

endpackage

// ==== design/clkreq_port_if.sv ====
/* Downstream port bundle */

`timescale 1ns/1ps

interface clkreq_port_if;

  // Synchronized agent request
  logic req_sync;
  // Port wants or still holds the clock
  logic need;
  // Port acknowledge is high
  logic acked;
  // Common grant from the upstream FSM
  logic grant;

  // Sync bank only drives the request
  modport sync (
    output req_sync
  );

  // Per agent FSM
  modport port (
    input  req_sync,
    input  grant,
    output need,
    output acked
  );

  // Upstream FSM collects need and fans out grant
  modport sm (
    input  need,
    input  acked,
    output grant
  );

endinterface

// ==== design/clkreqaggr_sync.sv ====
/* Request and acknowledge synchronizers */

`timescale 1ns/1ps

`include "clkreqaggr_cfg.svh"

module clkreqaggr_sync #(
  parameter int CLKREQ_CNT = `CLKREQAGGR_CNT
) (
  input  logic                  iclk,
  input  logic                  rst,
  // Async downstream requests
  input  logic [CLKREQ_CNT-1:0] iclkreq,
  // Async upstream acknowledge
  input  logic                  iclkmack,
  output logic                  mack_sync,
  // Unsynchronized OR, only used to hold off release
  output logic                  any_req_raw,
  clkreq_port_if.sync           port_if [CLKREQ_CNT-1:0]
);

  localparam int STAGES = `CLKREQAGGR_SYNC_STAGES;

  // Stage 0 samples the async pins
  logic [STAGES-1:0][CLKREQ_CNT-1:0] req_ff;
  logic [STAGES-1:0]                 mack_ff;

  // Request chains, one column per agent
  always_ff @(posedge iclk) begin
    if (rst) begin
      req_ff <= '0;
    end else begin
      req_ff[0] <= iclkreq;
      for (int s = 1; s < STAGES; s++) begin
        req_ff[s] <= req_ff[s-1];
      end
    end
  end

  // Upstream acknowledge chain
  always_ff @(posedge iclk) begin
    if (rst) begin
      mack_ff <= '0;
    end else begin
      mack_ff[0] <= iclkmack;
      for (int s = 1; s < STAGES; s++) begin
        mack_ff[s] <= mack_ff[s-1];
      end
    end
  end

  assign mack_sync = mack_ff[STAGES-1];

  // Fast path
  // Sees a new request before its chain settles, so the upstream
  // FSM cannot drop oclkmreq under a request still in flight
  assign any_req_raw = |iclkreq;

  // Last stage out to each port bundle
  for (genvar i = 0; i < CLKREQ_CNT; i++) begin : g_req_out
    assign port_if[i].req_sync = req_ff[STAGES-1][i];
  end

  // Synchronizer depth below two gives no settling time
  initial begin
    assert (STAGES >= 2)
      else $error("synchronizer depth must be at least 2");
  end

endmodule

// ==== design/clkreq_port.sv ====
/* Per agent acknowledge FSM */

`timescale 1ns/1ps

module clkreq_port (
  input  logic        iclk,
  input  logic        rst,
  clkreq_port_if.port port_if,
  // Acknowledge back to the agent
  output logic        oclkack
);

  import clkreqaggr_pkg::*;

  port_state_t state_q;
  port_state_t state_d;

  logic need_q;
  logic ack_q;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      PORT_IDLE: begin
        if (port_if.req_sync) begin
          // Upstream already on, skip the wait
          if (port_if.grant) begin
            state_d = PORT_ACK;
          end else begin
            state_d = PORT_WAIT;
          end
        end
      end
      PORT_WAIT: begin
        // Agent holds its request until acknowledged
        if (port_if.grant) begin
          state_d = PORT_ACK;
        end
      end
      PORT_ACK: begin
        if (!port_if.req_sync) begin
          state_d = PORT_DROP;
        end
      end
      PORT_DROP: begin
        // One cycle with need still up
        state_d = PORT_IDLE;
      end
      default: begin
        state_d = PORT_IDLE;
      end
    endcase
  end

  // State and registered outputs
  // need covers WAIT, ACK and DROP so release waits for a full drop
  always_ff @(posedge iclk) begin
    if (rst) begin
      state_q <= PORT_IDLE;
      need_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      need_q  <= (state_d != PORT_IDLE);
      ack_q   <= (state_d == PORT_ACK);
    end
  end

  assign port_if.need  = need_q;
  assign port_if.acked = ack_q;
  assign oclkack       = ack_q;

  // Ack only ever rises under the common grant
  a_ack_needs_grant : assert property (
    @(posedge iclk) disable iff (rst)
    (oclkack && !$past(oclkack)) |-> $past(port_if.grant)
  ) else $error("oclkack rose without grant");

  // Ack held until the agent has dropped its request
  a_ack_held : assert property (
    @(posedge iclk) disable iff (rst)
    (!oclkack && $past(oclkack)) |-> !$past(port_if.req_sync)
  ) else $error("oclkack fell while request still high");

endmodule

// ==== design/clkreqaggr_sm.sv ====
/* Upstream request FSM */

`timescale 1ns/1ps

`include "clkreqaggr_cfg.svh"

module clkreqaggr_sm #(
  parameter int CLKREQ_CNT = `CLKREQAGGR_CNT
) (
  input  logic      iclk,
  input  logic      rst,
  // Synchronized upstream acknowledge
  input  logic      mack_sync,
  // Raw OR of all agent requests
  input  logic      any_req_raw,
  clkreq_port_if.sm port_if [CLKREQ_CNT-1:0],
  // Upstream clock request
  output logic      oclkmreq
);

  import clkreqaggr_pkg::*;

  up_state_t state_q;
  up_state_t state_d;

  logic [CLKREQ_CNT-1:0] need_vec;
  logic [CLKREQ_CNT-1:0] acked_vec;
  logic                  any_need;
  logic                  mreq_q;
  logic                  grant_q;

  // Gather per port status, fan out the grant
  for (genvar i = 0; i < CLKREQ_CNT; i++) begin : g_port
    assign need_vec[i]      = port_if[i].need;
    assign acked_vec[i]     = port_if[i].acked;
    assign port_if[i].grant = grant_q;
  end

  assign any_need = |need_vec;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      UP_IDLE: begin
        // Previous handshake fully closed before a new request
        if (any_need && !mack_sync) begin
          state_d = UP_REQ;
        end
      end
      UP_REQ: begin
        if (mack_sync) begin
          state_d = UP_ON;
        end
      end
      UP_ON: begin
        // Raw path blocks release while a request is still syncing
        if (!any_need && !any_req_raw) begin
          state_d = UP_REL;
        end
      end
      UP_REL: begin
        // New requests wait here until iclkmack is low
        if (!mack_sync) begin
          state_d = UP_IDLE;
        end
      end
      default: begin
        state_d = UP_IDLE;
      end
    endcase
  end

  // State and registered outputs
  always_ff @(posedge iclk) begin
    if (rst) begin
      state_q <= UP_IDLE;
      mreq_q  <= 1'b0;
      grant_q <= 1'b0;
    end else begin
      state_q <= state_d;
      mreq_q  <= (state_d == UP_REQ) || (state_d == UP_ON);
      grant_q <= (state_d == UP_ON);
    end
  end

  assign oclkmreq = mreq_q;

  // Four phase upstream rule, no new request over a stale ack
  a_mreq_rise : assert property (
    @(posedge iclk) disable iff (rst)
    (oclkmreq && !$past(oclkmreq)) |-> !$past(mack_sync)
  ) else $error("oclkmreq rose while iclkmack still high");

  // Grant only inside an open upstream request
  a_grant_mreq : assert property (
    @(posedge iclk) disable iff (rst)
    grant_q |-> oclkmreq
  ) else $error("grant high without oclkmreq");

  // No port may still hold an ack once grant is gone
  a_acked_grant : assert property (
    @(posedge iclk) disable iff (rst)
    (|acked_vec) |-> grant_q
  ) else $error("port acknowledged without grant");

endmodule

// ==== design/clkreqaggr.sv ====
/* Clock request aggregator top */

`timescale 1ns/1ps

`include "clkreqaggr_cfg.svh"

module clkreqaggr #(
  parameter int CLKREQ_CNT = `CLKREQAGGR_CNT
) (
  input  logic                  iclk,
  // Synchronous, active high
  input  logic                  rst,
  // Downstream handshake, requests async
  input  logic [CLKREQ_CNT-1:0] iclkreq,
  output logic [CLKREQ_CNT-1:0] oclkack,
  // Upstream handshake, ack async
  output logic                  oclkmreq,
  input  logic                  iclkmack
);

  logic mack_sync;
  logic any_req_raw;

  // One bundle per downstream agent
  clkreq_port_if port_if [CLKREQ_CNT-1:0] ();

  // Synchronizers
  clkreqaggr_sync #(
    .CLKREQ_CNT (CLKREQ_CNT)
  ) i_sync (
    .iclk        (iclk),
    .rst         (rst),
    .iclkreq     (iclkreq),
    .iclkmack    (iclkmack),
    .mack_sync   (mack_sync),
    .any_req_raw (any_req_raw),
    .port_if     (port_if)
  );

  // Per agent acknowledge FSMs
  for (genvar i = 0; i < CLKREQ_CNT; i++) begin : g_port
    clkreq_port i_port (
      .iclk    (iclk),
      .rst     (rst),
      .port_if (port_if[i]),
      .oclkack (oclkack[i])
    );
  end

  // Upstream request FSM
  clkreqaggr_sm #(
    .CLKREQ_CNT (CLKREQ_CNT)
  ) i_sm (
    .iclk        (iclk),
    .rst         (rst),
    .mack_sync   (mack_sync),
    .any_req_raw (any_req_raw),
    .port_if     (port_if),
    .oclkmreq    (oclkmreq)
  );

endmodule

// ==== verif/tb_clkreqaggr.sv ====
/* Clock request aggregator testbench */

`timescale 1ns/1ps

`include "clkreqaggr_cfg.svh"

module tb_clkreqaggr;

  localparam int N       = `CLKREQAGGR_CNT;
  // Sync depth plus the registered ack
  localparam int LAT     = `CLKREQAGGR_SYNC_STAGES + 1;
  localparam int TIMEOUT = 200;
  localparam int NROWS   = 12;

  // Signal selectors for the bounded wait
  localparam int SIG_MREQ = 0;
  localparam int SIG_ACK  = 1;

  // One scenario of request mask, upstream delay, hold cycles and randomize flag
  typedef struct packed {
    logic [N-1:0] mask;
    int           delay;
    int           hold;
    bit           rnd;
  } row_t;

  logic         iclk = 1'b0;
  logic         rst;
  logic [N-1:0] iclkreq;
  logic [N-1:0] oclkack;
  logic         oclkmreq;
  logic         iclkmack = 1'b0;

  // Upstream responder state
  int   mack_delay = 0;
  int   mack_cnt   = 0;
  logic mreq_seen  = 1'b0;

  // Monitor state
  logic         mon_en    = 1'b0;
  logic         mreq_prev = 1'b0;
  logic [N-1:0] ack_prev  = '0;
  logic [N-1:0] row_mask;

  int   seed = 67010;
  row_t rows [NROWS];

  clkreqaggr #(
    .CLKREQ_CNT (N)
  ) i_clkreqaggr (
    .iclk     (iclk),
    .rst      (rst),
    .iclkreq  (iclkreq),
    .oclkack  (oclkack),
    .oclkmreq (oclkmreq),
    .iclkmack (iclkmack)
  );

  // 20 ns clock
  always #10 iclk = ~iclk;

  // Upstream agent mirrors oclkmreq on iclkmack after mack_delay cycles
  always @(negedge iclk) begin
    mreq_seen = oclkmreq;
  end

  always @(posedge iclk) begin
    if (rst) begin
      iclkmack <= 1'b0;
      mack_cnt <= 0;
    end else if (mreq_seen != iclkmack) begin
      if (mack_cnt >= mack_delay) begin
        iclkmack <= mreq_seen;
        mack_cnt <= 0;
      end else begin
        mack_cnt <= mack_cnt + 1;
      end
    end else begin
      mack_cnt <= 0;
    end
  end

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s (expected %0h, got %0h)", $time, msg, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Protocol monitor on the falling edge away from DUT updates
  always @(negedge iclk) begin
    if (mon_en) begin
      check_eq(32'(oclkmreq & ~mreq_prev & iclkmack), 32'd0,
               "oclkmreq rose while iclkmack high");
      check_eq(32'((|oclkack) & ~iclkmack), 32'd0, "oclkack high while iclkmack low");
      check_eq(32'((|(oclkack & ~ack_prev)) & ~oclkmreq), 32'd0,
               "oclkack rose without oclkmreq");
      // Only ports of the current row may be acknowledged
      check_eq(32'(oclkack & ~row_mask), 32'd0, "oclkack on a port with no request");
    end
    mreq_prev = oclkmreq;
    ack_prev  = oclkack;
  end

  function automatic logic sample_signal(input int sel, input int idx);
    if (sel == SIG_MREQ) begin
      return oclkmreq;
    end
    return oclkack[idx];
  endfunction

  // Bounded wait for a level on oclkmreq or one oclkack bit
  task automatic wait_level(input int sel, input int idx, input logic val, input string what);
    int cnt;
    @(negedge iclk);
    for (cnt = 0; cnt < TIMEOUT && sample_signal(sel, idx) !== val; cnt++) begin
      @(negedge iclk);
    end
    if (sample_signal(sel, idx) !== val) begin
      $display("Timeout: %s did not arrive within %0d cycles", what, TIMEOUT);
      $display("Simulation FAILED");
      $fatal(1, "wait timeout");
    end
  endtask

  // With upstream on the ack edge follows the request edge by LAT cycles
  // Check at the falling edge after each rising edge up to edge LAT
  task automatic measure_latency(input int idx, input logic val);
    @(posedge iclk);
    row_mask[idx] = 1'b1;
    iclkreq[idx] <= val;
    for (int c = 0; c <= LAT; c++) begin
      @(negedge iclk);
      check_eq(32'(oclkack[idx]), (c == LAT) ? 32'(val) : 32'(!val),
               $sformatf("oclkack[%0d] latency, cycle %0d", idx, c));
    end
  endtask

  task automatic run_row(input row_t row);
    logic [N-1:0] mask;
    int           hold;
    int           late;
    mask       = row.mask;
    hold       = row.hold;
    mack_delay = row.delay;
    if (row.rnd) begin
      mask       = N'($unsigned($random(seed)));
      mack_delay = int'($unsigned($random(seed)) % 8);
      hold       = int'($unsigned($random(seed)) % 8);
      if (mask == '0) begin
        mask[0] = 1'b1;
      end
    end
    // Lowest idle port serves the latency check
    late = -1;
    for (int i = N - 1; i >= 0; i--) begin
      if (!mask[i]) begin
        late = i;
      end
    end

    @(posedge iclk);
    row_mask = mask;
    iclkreq <= mask;
    wait_level(SIG_MREQ, 0, 1'b1, "oclkmreq rise");
    for (int i = 0; i < N; i++) begin
      if (mask[i]) begin
        wait_level(SIG_ACK, i, 1'b1, $sformatf("oclkack[%0d] rise", i));
      end
    end

    if (late >= 0) begin
      measure_latency(late, 1'b1);
      repeat (hold) @(posedge iclk);
      measure_latency(late, 1'b0);
    end
    repeat (hold) @(posedge iclk);

    // Release one by one while upstream stays on until the last is gone
    for (int i = 0; i < N; i++) begin
      if (mask[i]) begin
        @(posedge iclk);
        iclkreq[i] <= 1'b0;
        wait_level(SIG_ACK, i, 1'b0, $sformatf("oclkack[%0d] fall", i));
        check_eq(32'(oclkmreq), 32'd1, "oclkmreq fell before the last release");
      end
    end
    wait_level(SIG_MREQ, 0, 1'b0, "oclkmreq fall");
  endtask

  initial begin
    rst      = 1'b1;
    iclkreq  = '0;
    row_mask = '0;

    // Single requests lead the overlapping and random rows
    rows[0]  = '{4'b0001, 0, 2, 1'b0};
    rows[1]  = '{4'b0100, 5, 3, 1'b0};
    rows[2]  = '{4'b0011, 2, 1, 1'b0};
    rows[3]  = '{4'b1011, 7, 4, 1'b0};
    rows[4]  = '{4'b1111, 1, 2, 1'b0};
    rows[5]  = '{4'b0110, 3, 0, 1'b0};
    for (int r = 6; r < NROWS; r++) begin
      rows[r] = '{4'b0000, 0, 0, 1'b1};
    end

    repeat (8) @(posedge iclk);
    rst <= 1'b0;

    // Quiet after reset
    repeat (10) begin
      @(negedge iclk);
      check_eq(32'(oclkmreq), 32'd0, "oclkmreq high while idle");
      check_eq(32'(oclkack), 32'd0, "oclkack high while idle");
    end
    @(posedge iclk);
    mon_en = 1'b1;

    for (int r = 0; r < NROWS; r++) begin
      run_row(rows[r]);
    end

    repeat (5) @(posedge iclk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+design
design/clkreqaggr_pkg.sv
design/clkreq_port_if.sv
design/clkreqaggr_sync.sv
design/clkreq_port.sv
design/clkreqaggr_sm.sv
design/clkreqaggr.sv
verif/tb_clkreqaggr.sv

// ==== Makefile ====
TOP = tb_clkreqaggr

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f src.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
